/* cpu_pkg.sv */
package cpu_pkg;

    localparam int data_bits = 32;
    localparam int reg_bits  = 4;
    localparam int imm_bits  = 16;

    // Board I/O widths
    localparam int hex_bits  = 24;
    localparam int ledr_bits = 10;
    localparam int key_bits  = 4;
    localparam int sw_bits   = 10;

    localparam int imem_words = 4096;
    localparam int dmem_words = 4096;

    localparam logic [data_bits-1:0] start_pc  = 32'h100;
    localparam logic [data_bits-1:0] inst_size = 32'd4;

    // Memory-mapped I/O locations
    localparam logic [data_bits-1:0] addr_hex  = 32'hFFFFF000;
    localparam logic [data_bits-1:0] addr_ledr = 32'hFFFFF020;
    localparam logic [data_bits-1:0] addr_key  = 32'hFFFFF080;
    localparam logic [data_bits-1:0] addr_sw   = 32'hFFFFF090;
    localparam logic [hex_bits-1:0]  hex_reset = 24'hFEDEAD;

    localparam logic [5:0] op1_alur = 6'b000000;
    localparam logic [5:0] op1_beq  = 6'b001000;
    localparam logic [5:0] op1_blt  = 6'b001001;
    localparam logic [5:0] op1_ble  = 6'b001010;
    localparam logic [5:0] op1_bne  = 6'b001011;
    localparam logic [5:0] op1_jal  = 6'b001100;
    localparam logic [5:0] op1_lw   = 6'b010010;
    localparam logic [5:0] op1_sw   = 6'b011010;
    localparam logic [5:0] op1_addi = 6'b100000;
    localparam logic [5:0] op1_andi = 6'b100100;
    localparam logic [5:0] op1_ori  = 6'b100101;
    localparam logic [5:0] op1_xori = 6'b100110;

    // Secondary opcodes of ALUR
    localparam logic [7:0] op2_eq   = 8'b00001000;
    localparam logic [7:0] op2_lt   = 8'b00001001;
    localparam logic [7:0] op2_le   = 8'b00001010;
    localparam logic [7:0] op2_ne   = 8'b00001011;
    localparam logic [7:0] op2_add  = 8'b00100000;
    localparam logic [7:0] op2_and  = 8'b00100100;
    localparam logic [7:0] op2_or   = 8'b00100101;
    localparam logic [7:0] op2_xor  = 8'b00100110;
    localparam logic [7:0] op2_sub  = 8'b00101000;
    localparam logic [7:0] op2_nand = 8'b00101100;
    localparam logic [7:0] op2_nor  = 8'b00101101;
    localparam logic [7:0] op2_nxor = 8'b00101110;
    localparam logic [7:0] op2_rshf = 8'b00110000;
    localparam logic [7:0] op2_lshf = 8'b00110001;

    typedef enum logic [1:0] {
        wb_pc  = 2'd0,  // Link address for JAL
        wb_mem = 2'd1,
        wb_alu = 2'd2
    } wb_src_t;

    typedef struct packed {
        logic [5:0]          op1;
        logic [7:0]          op2;
        logic [5:0]          unused;
        logic [reg_bits-1:0] rd;
        logic [reg_bits-1:0] rs;
        logic [reg_bits-1:0] rt;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]          op1;
        logic [1:0]          unused;
        logic [imm_bits-1:0] imm;
        logic [reg_bits-1:0] rs;
        logic [reg_bits-1:0] rt;
    } inst_i_t;

    // Same word seen as register form or immediate form
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_t;

    typedef struct packed {
        logic                 valid;
        inst_t                inst;
        logic [data_bits-1:0] pc_plus;
    } fe_id_t;

    typedef struct packed {
        logic                 valid;
        logic [5:0]           op1;
        logic [7:0]           op2;
        logic [data_bits-1:0] rs_val;
        logic [data_bits-1:0] rt_val;
        logic [data_bits-1:0] imm_sxt;
        logic [reg_bits-1:0]  dst;
        logic                 reg_we;
        logic                 mem_re;
        logic                 mem_we;
        wb_src_t              wb_src;
        logic [data_bits-1:0] pc_plus;
    } id_ex_t;

    typedef struct packed {
        logic [data_bits-1:0] alu_out;   // Also the memory address
        logic [data_bits-1:0] store_val;
        logic [reg_bits-1:0]  dst;
        logic                 reg_we;
        logic                 mem_re;
        logic                 mem_we;
        wb_src_t              wb_src;
        logic [data_bits-1:0] pc_plus;
    } ex_mem_t;

    typedef struct packed {
        logic                 we;
        logic [reg_bits-1:0]  addr;
        logic [data_bits-1:0] data;
    } reg_write_t;

    function automatic logic is_branch_op(input logic [5:0] op1);
        return op1 inside {op1_beq, op1_blt, op1_ble, op1_bne};
    endfunction

endpackage

/* fetch_stage.sv */
module fetch_stage import cpu_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          prog_we,
    input  logic [$clog2(imem_words)-1:0] prog_addr,
    input  inst_t                         prog_data,
    input  logic                          stall,
    input  logic                          jal_taken,
    input  logic [data_bits-1:0]          jal_target,
    input  logic                          mispredict,
    output fe_id_t                        fe_id
);

    inst_t                imem [imem_words];
    logic [data_bits-1:0] pc;
    logic [data_bits-1:0] pc_plus;
    logic [data_bits-1:0] ft_dec;     // Fall-through of a branch sitting in decode
    logic [data_bits-1:0] ft_exe;     // Fall-through of a branch sitting in execute
    logic [data_bits-1:0] br_target;
    inst_t                inst;

    // Program load port
    always_ff @(posedge clk) begin
        if (prog_we)
            imem[prog_addr] <= prog_data;
    end

    assign inst      = imem[pc[$clog2(imem_words)+1:2]];
    assign pc_plus   = pc + inst_size;
    assign br_target = pc_plus + {{(data_bits-imm_bits-2){inst.i.imm[imm_bits-1]}},
                                  inst.i.imm, 2'b00};

    // Every branch is predicted taken
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc     <= start_pc;
            ft_dec <= start_pc;
            ft_exe <= start_pc;
        end else if (mispredict) begin
            pc <= ft_exe;                 // Recover the not-taken path
        end else if (!stall) begin
            ft_exe <= ft_dec;             // Follows the branch into execute
            if (jal_taken) begin
                pc <= jal_target;
            end else if (is_branch_op(inst.i.op1)) begin
                pc     <= br_target;
                ft_dec <= pc_plus;
            end else begin
                pc <= pc_plus;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fe_id <= '0;
        end else if (mispredict || (!stall && jal_taken)) begin
            fe_id.valid <= 1'b0;          // Squash the wrong-path fetch
        end else if (!stall) begin
            fe_id.valid   <= 1'b1;
            fe_id.inst    <= inst;
            fe_id.pc_plus <= pc_plus;
        end
    end

endmodule

/* register_file.sv */
module register_file import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [reg_bits-1:0]  rs,
    input  logic [reg_bits-1:0]  rt,
    output logic [data_bits-1:0] rs_val,
    output logic [data_bits-1:0] rt_val,
    input  reg_write_t           wb
);

    logic [data_bits-1:0] regs [2**reg_bits];

    // r0 is hardwired, same-cycle write is bypassed
    function automatic logic [data_bits-1:0] read_port(input logic [reg_bits-1:0] a);
        if (a == '0)
            return '0;
        if (wb.we && wb.addr == a)
            return wb.data;
        return regs[a];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_bits; i++)
                regs[i] <= '0;
        end else if (wb.we && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    always_comb begin
        rs_val = read_port(rs);
        rt_val = read_port(rt);
    end

endmodule

/* decode_stage.sv */
module decode_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  fe_id_t               fe_id,
    input  logic                 mispredict,
    input  ex_mem_t              ex_mem,
    input  reg_write_t           wb,
    output logic                 stall,
    output logic                 jal_taken,
    output logic [data_bits-1:0] jal_target,
    output id_ex_t               id_ex
);

    inst_t                inst;
    logic [5:0]           op1;
    logic [data_bits-1:0] rs_val;
    logic [data_bits-1:0] rt_val;
    logic [data_bits-1:0] imm_sxt;
    logic                 is_alur;
    logic                 is_jal;
    logic                 is_lw;
    logic                 is_sw;
    logic                 is_immop;
    logic                 reads_rt;
    logic                 rs_busy;
    logic                 rt_busy;
    id_ex_t               id_ex_d;

    // Register still owed by an older instruction
    function automatic logic pending(input logic [reg_bits-1:0] r);
        return r != '0 && ((id_ex.reg_we && id_ex.dst == r) ||
                           (ex_mem.reg_we && ex_mem.dst == r) ||
                           (wb.we && wb.addr == r));
    endfunction

    register_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .rs     (inst.r.rs),
        .rt     (inst.r.rt),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .wb     (wb)
    );

    assign inst    = fe_id.inst;
    assign op1     = inst.r.op1;
    assign imm_sxt = {{(data_bits-imm_bits){inst.i.imm[imm_bits-1]}}, inst.i.imm};

    assign is_alur  = op1 == op1_alur;
    assign is_jal   = op1 == op1_jal;
    assign is_lw    = op1 == op1_lw;
    assign is_sw    = op1 == op1_sw;
    assign is_immop = op1 inside {op1_addi, op1_andi, op1_ori, op1_xori};
    assign reads_rt = is_alur || is_branch_op(op1) || is_sw;  // rt is a source only here

    always_comb begin
        rs_busy = pending(inst.r.rs);
        rt_busy = reads_rt && pending(inst.r.rt);
    end

    assign stall      = fe_id.valid && (rs_busy || rt_busy);
    assign jal_taken  = fe_id.valid && is_jal && !stall && !mispredict;
    assign jal_target = rs_val + {imm_sxt[data_bits-3:0], 2'b00};

    always_comb begin
        id_ex_d.valid   = fe_id.valid;
        id_ex_d.op1     = op1;
        id_ex_d.op2     = inst.r.op2;
        id_ex_d.rs_val  = rs_val;
        id_ex_d.rt_val  = rt_val;
        id_ex_d.imm_sxt = imm_sxt;
        id_ex_d.dst     = is_alur ? inst.r.rd : inst.r.rt;
        id_ex_d.reg_we  = fe_id.valid && (is_alur || is_jal || is_lw || is_immop);
        id_ex_d.mem_re  = fe_id.valid && is_lw;
        id_ex_d.mem_we  = fe_id.valid && is_sw;
        id_ex_d.wb_src  = is_jal ? wb_pc : (is_lw ? wb_mem : wb_alu);
        id_ex_d.pc_plus = fe_id.pc_plus;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else if (mispredict || stall) begin
            id_ex.valid  <= 1'b0;   // Bubble
            id_ex.reg_we <= 1'b0;
            id_ex.mem_re <= 1'b0;
            id_ex.mem_we <= 1'b0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

/* execute_stage.sv */
module execute_stage import cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  id_ex_t  id_ex,
    output logic    mispredict,
    output ex_mem_t ex_mem
);

    logic                 is_branch;
    logic [data_bits-1:0] op_a;
    logic [data_bits-1:0] op_b;
    logic [data_bits-1:0] alu_out;
    logic                 br_cond;

    assign is_branch = is_branch_op(id_ex.op1);
    assign op_a      = id_ex.rs_val;
    assign op_b      = (id_ex.op1 == op1_alur || is_branch) ? id_ex.rt_val : id_ex.imm_sxt;

    always_comb begin
        alu_out = '0;
        case (id_ex.op1)
            op1_alur: begin
                case (id_ex.op2)
                    op2_eq:   alu_out[0] = op_a == op_b;
                    op2_lt:   alu_out[0] = $signed(op_a) < $signed(op_b);
                    op2_le:   alu_out[0] = $signed(op_a) <= $signed(op_b);
                    op2_ne:   alu_out[0] = op_a != op_b;
                    op2_add:  alu_out = op_a + op_b;
                    op2_sub:  alu_out = op_a - op_b;
                    op2_and:  alu_out = op_a & op_b;
                    op2_or:   alu_out = op_a | op_b;
                    op2_xor:  alu_out = op_a ^ op_b;
                    op2_nand: alu_out = ~(op_a & op_b);
                    op2_nor:  alu_out = ~(op_a | op_b);
                    op2_nxor: alu_out = ~(op_a ^ op_b);
                    op2_lshf: alu_out = op_a << op_b;
                    op2_rshf: alu_out = $signed(op_a) >>> op_b;  // Keeps the sign
                    default:  alu_out = '0;
                endcase
            end
            op1_lw, op1_sw, op1_addi: alu_out = op_a + op_b;
            op1_andi: alu_out = op_a & op_b;
            op1_ori:  alu_out = op_a | op_b;
            op1_xori: alu_out = op_a ^ op_b;
            default:  alu_out = '0;
        endcase
    end

    always_comb begin
        case (id_ex.op1)
            op1_beq: br_cond = op_a == op_b;
            op1_blt: br_cond = $signed(op_a) < $signed(op_b);
            op1_ble: br_cond = $signed(op_a) <= $signed(op_b);
            op1_bne: br_cond = op_a != op_b;
            default: br_cond = 1'b1;
        endcase
    end

    // Prediction was taken, so a false condition is the miss
    assign mispredict = id_ex.valid && is_branch && !br_cond;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else if (mispredict) begin
            ex_mem.reg_we <= 1'b0;
            ex_mem.mem_re <= 1'b0;
            ex_mem.mem_we <= 1'b0;
        end else begin
            ex_mem.alu_out   <= alu_out;
            ex_mem.store_val <= id_ex.rt_val;
            ex_mem.dst       <= id_ex.dst;
            ex_mem.reg_we    <= id_ex.reg_we;
            ex_mem.mem_re    <= id_ex.mem_re;
            ex_mem.mem_we    <= id_ex.mem_we;
            ex_mem.wb_src    <= id_ex.wb_src;
            ex_mem.pc_plus   <= id_ex.pc_plus;
        end
    end

endmodule

/* memory_stage.sv */
module memory_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  ex_mem_t              ex_mem,
    input  logic [key_bits-1:0]  key,
    input  logic [sw_bits-1:0]   sw,
    output logic [hex_bits-1:0]  hex,
    output logic [ledr_bits-1:0] ledr,
    output reg_write_t           wb
);

    logic [data_bits-1:0]          dmem [dmem_words];
    logic [$clog2(dmem_words)-1:0] word_idx;
    logic                          is_io;
    logic [data_bits-1:0]          load_val;
    logic [data_bits-1:0]          wb_data;

    assign word_idx = ex_mem.alu_out[$clog2(dmem_words)+1:2];
    assign is_io    = ex_mem.alu_out inside {addr_hex, addr_ledr, addr_key, addr_sw};

    // I/O addresses never alias into data memory
    always_ff @(posedge clk) begin
        if (ex_mem.mem_we && !is_io)
            dmem[word_idx] <= ex_mem.store_val;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hex  <= hex_reset;
            ledr <= '0;
        end else if (ex_mem.mem_we) begin
            if (ex_mem.alu_out == addr_hex)
                hex <= ex_mem.store_val[hex_bits-1:0];
            if (ex_mem.alu_out == addr_ledr)
                ledr <= ex_mem.store_val[ledr_bits-1:0];
        end
    end

    always_comb begin
        load_val = '0;
        if (ex_mem.mem_re) begin
            case (ex_mem.alu_out)
                addr_key: load_val = {{(data_bits-key_bits){1'b0}}, ~key};  // Keys are active low
                addr_sw:  load_val = {{(data_bits-sw_bits){1'b0}}, sw};
                default:  load_val = dmem[word_idx];
            endcase
        end
    end

    always_comb begin
        case (ex_mem.wb_src)
            wb_pc:   wb_data = ex_mem.pc_plus;
            wb_mem:  wb_data = load_val;
            default: wb_data = ex_mem.alu_out;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.we   <= ex_mem.reg_we;
            wb.addr <= ex_mem.dst;
            wb.data <= wb_data;
        end
    end

endmodule

/* cpu_top.sv */
module cpu_top import cpu_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          prog_we,
    input  logic [$clog2(imem_words)-1:0] prog_addr,
    input  inst_t                         prog_data,
    input  logic [key_bits-1:0]           key,
    input  logic [sw_bits-1:0]            sw,
    output logic [hex_bits-1:0]           hex,
    output logic [ledr_bits-1:0]          ledr
);

    fe_id_t               fe_id;
    id_ex_t               id_ex;
    ex_mem_t              ex_mem;
    reg_write_t           wb;
    logic                 stall;
    logic                 jal_taken;
    logic [data_bits-1:0] jal_target;
    logic                 mispredict;

    fetch_stage u_fetch (
        .clk        (clk),
        .reset      (reset),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .stall      (stall),
        .jal_taken  (jal_taken),
        .jal_target (jal_target),
        .mispredict (mispredict),
        .fe_id      (fe_id)
    );

    decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .fe_id      (fe_id),
        .mispredict (mispredict),
        .ex_mem     (ex_mem),
        .wb         (wb),         // Register write and hazard check
        .stall      (stall),
        .jal_taken  (jal_taken),
        .jal_target (jal_target),
        .id_ex      (id_ex)
    );

    execute_stage u_execute (
        .clk        (clk),
        .reset      (reset),
        .id_ex      (id_ex),
        .mispredict (mispredict),
        .ex_mem     (ex_mem)
    );

    memory_stage u_memory (
        .clk    (clk),
        .reset  (reset),
        .ex_mem (ex_mem),
        .key    (key),
        .sw     (sw),
        .hex    (hex),
        .ledr   (ledr),
        .wb     (wb)
    );

endmodule

/* tb_asm.svh */
// Register form computes rd = rs op2 rt
function automatic logic [31:0] r_form(input logic [7:0] op2,
                                       input logic [3:0] rd,
                                       input logic [3:0] rs,
                                       input logic [3:0] rt);
    return {op1_alur, op2, 6'b000000, rd, rs, rt};
endfunction

// In the immediate form rt is the destination or the store source
function automatic logic [31:0] i_form(input logic [5:0] op1,
                                       input logic [3:0] rt,
                                       input logic [3:0] rs,
                                       input logic [15:0] imm);
    return {op1, 2'b00, imm, rs, rt};
endfunction

// I/O addresses sign-extend from their low 16 bits
function automatic logic [31:0] io_store(input logic [3:0] rt, input logic [31:0] addr);
    return i_form(op1_sw, rt, 4'd0, addr[15:0]);
endfunction

function automatic logic [31:0] io_load(input logic [3:0] rt, input logic [31:0] addr);
    return i_form(op1_lw, rt, 4'd0, addr[15:0]);
endfunction

// Branch to itself that keeps fetch inside the program
function automatic logic [31:0] halt_word();
    return i_form(op1_beq, 4'd0, 4'd0, 16'hFFFF);
endfunction

// Writes prog from start_pc on at one word per clock
task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
        @(negedge clk);
        prog_we   = 1'b1;
        prog_addr = start_pc[13:2] + 12'(i);
        prog_data = prog[i];
    end
    @(negedge clk);
    prog_we = 1'b0;
endtask

/* tb_cpu.sv */
module tb_cpu import cpu_pkg::*; ();

    localparam int n_tests     = 6;
    localparam int cycle_limit = 400;               // Budget per test
    localparam int wait_limit  = cycle_limit / 2;   // For the done write

    logic                 clk;
    logic                 reset;
    logic                 prog_we;
    logic [11:0]          prog_addr;
    inst_t                prog_data;
    logic [key_bits-1:0]  key;
    logic [sw_bits-1:0]   sw;
    logic [hex_bits-1:0]  hex;
    logic [ledr_bits-1:0] ledr;

    logic [31:0] prog [$];
    int          errors;
    int          tests_run;

    `include "tb_asm.svh"

    cpu_top uut (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .key       (key),
        .sw        (sw),
        .hex       (hex),
        .ledr      (ledr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(n_tests * cycle_limit * 100);
        $display("Watchdog expired after %0d cycles, the run did not finish",
                 n_tests * cycle_limit);
        $display("Done: errors found");
        $finish;
    end

    function automatic logic [31:0] sxt16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // Core sits in reset while its program is written
    task automatic start_program();
        @(negedge clk);
        reset = 1'b1;
        repeat (5) @(negedge clk);
        load_program();
        reset = 1'b0;
    endtask

    task automatic wait_for_done(input bit on_hex, input string test);
        int n;
        n = 0;
        while (n < wait_limit && (on_hex ? hex == hex_reset : ledr == '0)) begin
            @(negedge clk);
            n++;
        end
        if (on_hex ? hex == hex_reset : ledr == '0) begin
            $display("%s: no write to %s within %0d cycles",
                     test, on_hex ? "hex" : "ledr", wait_limit);
            errors++;
        end
    endtask

    task automatic finish_test(input string test, input int errors_before);
        tests_run++;
        $display("%-8s %s", test, (errors == errors_before) ? "passed" : "FAILED");
    endtask

    task automatic alu_ops();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] s;
        logic [31:0] v;
        int          errors_before;
        errors_before = errors;
        a = 16'($urandom);
        b = 16'($urandom);
        s = 16'($urandom % 8);
        v = ~((sxt16(a) - sxt16(b)) & sxt16(a));
        v = (v ^ sxt16(b)) << s;
        v = v + (($signed(sxt16(a)) < $signed(sxt16(b))) ? 32'd1 : 32'd0);
        prog.delete();
        prog.push_back(i_form(op1_addi, 4'd1, 4'd0, a));
        prog.push_back(i_form(op1_addi, 4'd2, 4'd0, b));
        prog.push_back(i_form(op1_addi, 4'd3, 4'd0, s));
        prog.push_back(r_form(op2_sub, 4'd4, 4'd1, 4'd2));
        prog.push_back(r_form(op2_nand, 4'd5, 4'd4, 4'd1));
        prog.push_back(r_form(op2_xor, 4'd6, 4'd5, 4'd2));
        prog.push_back(r_form(op2_lshf, 4'd7, 4'd6, 4'd3));
        prog.push_back(r_form(op2_lt, 4'd8, 4'd1, 4'd2));   // Signed compare gives 0 or 1
        prog.push_back(r_form(op2_add, 4'd9, 4'd7, 4'd8));
        prog.push_back(io_store(4'd9, addr_hex));
        prog.push_back(i_form(op1_addi, 4'd10, 4'd0, 16'd1));
        prog.push_back(io_store(4'd10, addr_ledr));          // Done flag
        prog.push_back(halt_word());
        start_program();
        wait_for_done(1'b0, "alu");
        check_value("hex", {8'h00, v[23:0]}, {8'h00, hex});
        finish_test("alu", errors_before);
    endtask

    // Every step reads the result of the one before
    task automatic dependency_chain();
        logic [15:0] c [8];
        logic [31:0] v;
        int          errors_before;
        errors_before = errors;
        foreach (c[k])
            c[k] = 16'($urandom);
        v = sxt16(c[0]) + sxt16(c[1]);
        v = (v & sxt16(c[2])) + sxt16(c[3]);
        v = (v & sxt16(c[4])) + sxt16(c[5]);
        v = (v | sxt16(c[6])) ^ sxt16(c[7]);
        prog.delete();
        prog.push_back(i_form(op1_addi, 4'd1, 4'd0, c[0]));
        prog.push_back(i_form(op1_addi, 4'd1, 4'd1, c[1]));
        prog.push_back(i_form(op1_andi, 4'd1, 4'd1, c[2]));
        prog.push_back(i_form(op1_addi, 4'd2, 4'd1, c[3]));
        prog.push_back(i_form(op1_andi, 4'd2, 4'd2, c[4]));
        prog.push_back(i_form(op1_addi, 4'd3, 4'd2, c[5]));
        prog.push_back(i_form(op1_ori, 4'd3, 4'd3, c[6]));
        prog.push_back(i_form(op1_xori, 4'd3, 4'd3, c[7]));
        prog.push_back(io_store(4'd3, addr_hex));
        prog.push_back(i_form(op1_addi, 4'd10, 4'd0, 16'd1));
        prog.push_back(io_store(4'd10, addr_ledr));
        prog.push_back(halt_word());
        start_program();
        wait_for_done(1'b0, "chain");
        check_value("hex", {8'h00, v[23:0]}, {8'h00, hex});
        finish_test("chain", errors_before);
    endtask

    task automatic load_store();
        logic [15:0] w0;
        logic [15:0] w1;
        logic [15:0] base;
        logic [31:0] v;
        int          errors_before;
        errors_before = errors;
        w0   = 16'($urandom);
        w1   = 16'($urandom);
        base = 16'(32'h1000 + ($urandom % 1024) * 4);  // Word aligned and positive
        v    = sxt16(w0) + sxt16(w1);
        prog.delete();
        prog.push_back(i_form(op1_addi, 4'd1, 4'd0, w0));
        prog.push_back(i_form(op1_addi, 4'd2, 4'd0, w1));
        prog.push_back(i_form(op1_addi, 4'd5, 4'd0, base));
        prog.push_back(i_form(op1_sw, 4'd1, 4'd5, 16'd0));
        prog.push_back(i_form(op1_sw, 4'd2, 4'd5, 16'd4));
        prog.push_back(i_form(op1_lw, 4'd3, 4'd5, 16'd0));
        prog.push_back(i_form(op1_lw, 4'd4, 4'd5, 16'd4));
        prog.push_back(r_form(op2_add, 4'd6, 4'd3, 4'd4));
        prog.push_back(io_store(4'd6, addr_hex));
        prog.push_back(i_form(op1_addi, 4'd7, 4'd0, 16'd1));
        prog.push_back(io_store(4'd7, addr_ledr));
        prog.push_back(halt_word());
        start_program();
        wait_for_done(1'b0, "memory");
        check_value("hex", {8'h00, v[23:0]}, {8'h00, hex});
        finish_test("memory", errors_before);
    endtask

    task automatic branch_flush();
        logic [15:0] a;
        int          errors_before;
        errors_before = errors;
        a = 16'($urandom);
        prog.delete();
        prog.push_back(i_form(op1_addi, 4'd1, 4'd0, a));
        prog.push_back(i_form(op1_addi, 4'd2, 4'd0, a));
        prog.push_back(i_form(op1_addi, 4'd5, 4'd0, 16'h00AA));  // Wrong marker
        prog.push_back(i_form(op1_addi, 4'd6, 4'd0, 16'h0155));  // Right marker
        prog.push_back(i_form(op1_addi, 4'd7, 4'd0, 16'd1));
        prog.push_back(i_form(op1_beq, 4'd2, 4'd1, 16'd1));      // Taken so the next store is skipped
        prog.push_back(io_store(4'd5, addr_ledr));
        prog.push_back(i_form(op1_bne, 4'd2, 4'd1, 16'd2));      // Falls through
        prog.push_back(io_store(4'd6, addr_ledr));
        prog.push_back(i_form(op1_beq, 4'd0, 4'd0, 16'd2));
        prog.push_back(i_form(op1_addi, 4'd6, 4'd0, 16'h00AA));  // Wrong path of bne
        prog.push_back(i_form(op1_addi, 4'd6, 4'd6, 16'h00AA));
        prog.push_back(io_store(4'd7, addr_hex));
        prog.push_back(halt_word());
        start_program();
        wait_for_done(1'b1, "branch");
        check_value("ledr", 32'h155, {22'b0, ledr});
        finish_test("branch", errors_before);
    endtask

    task automatic jal_link();
        logic [31:0] jal_addr;
        logic [31:0] link;
        int          errors_before;
        errors_before = errors;
        jal_addr = start_pc + 32'd8;
        link     = jal_addr + 32'd4;
        prog.delete();
        prog.push_back(i_form(op1_addi, 4'd1, 4'd0, 16'd5));
        prog.push_back(i_form(op1_addi, 4'd2, 4'd0, 16'h02AA));
        prog.push_back(i_form(op1_jal, 4'd15, 4'd0, 16'((start_pc + 32'd16) >> 2)));
        prog.push_back(io_store(4'd2, addr_ledr));   // Skipped by the jump
        prog.push_back(io_store(4'd15, addr_hex));   // Subroutine
        prog.push_back(io_store(4'd1, addr_ledr));
        prog.push_back(halt_word());
        start_program();
        wait_for_done(1'b0, "jal");
        check_value("hex", {8'h00, link[23:0]}, {8'h00, hex});
        check_value("ledr", 32'd5, {22'b0, ledr});
        finish_test("jal", errors_before);
    endtask

    task automatic io_read();
        logic [31:0] v;
        int          errors_before;
        errors_before = errors;
        @(negedge clk);
        key = 4'($urandom);
        sw  = 10'($urandom);
        v   = {28'b0, ~key} ^ {22'b0, sw};   // Keys read back inverted
        prog.delete();
        prog.push_back(io_load(4'd1, addr_key));
        prog.push_back(io_load(4'd2, addr_sw));
        prog.push_back(r_form(op2_xor, 4'd3, 4'd1, 4'd2));
        prog.push_back(io_store(4'd3, addr_ledr));
        prog.push_back(i_form(op1_addi, 4'd4, 4'd0, 16'd1));
        prog.push_back(io_store(4'd4, addr_hex));
        prog.push_back(halt_word());
        start_program();
        wait_for_done(1'b1, "io");
        check_value("ledr", {22'b0, v[9:0]}, {22'b0, ledr});
        finish_test("io", errors_before);
    endtask

    initial begin
        void'($urandom(83));
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        key       = '0;
        sw        = '0;
        errors    = 0;
        tests_run = 0;
        alu_ops();
        dependency_chain();
        load_store();
        branch_flush();
        jal_link();
        io_read();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* files.f */
+incdir+.
cpu_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
